/* common/conv_pkg.sv */
package conv_pkg;

  // pixel and output word
  localparam int DATA_W = 8;
  localparam int WT_W = 8;
  localparam int BIAS_W = 16;

  // nine 8x8 products plus a 16-bit bias stay well inside 20 bits
  localparam int ACC_W = 20;

  // img_size goes up to 16, so it needs one more bit than the column address
  localparam int SIZE_W = 5;
  localparam int ADDR_W = 4;
  localparam int IMG_MAX = 16;

  // window geometry
  localparam int KSIZE = 3;
  localparam int NTAP = 9;

  // fixed scaling of the biased sum
  localparam int OUT_SHIFT = 4;

  typedef logic signed [DATA_W-1:0] pixel_t;
  typedef logic signed [WT_W-1:0] weight_t;
  typedef logic signed [BIAS_W-1:0] bias_t;
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* common/ctrl_if.sv */
interface ctrl_if
  import conv_pkg::*;
  ();

  logic                       wr;
  logic [ADDR_W-1:0]          col;
  logic [$clog2(KSIZE)-1:0]   line_sel;
  logic                       win_ok;
  logic                       last;

  modport ctrl (
    output wr, col, line_sel, win_ok, last
  );

  modport buf_side (
    input wr, col, line_sel, win_ok, last
  );

endinterface

/* common/window_if.sv */
interface window_if
  import conv_pkg::*;
  ();

  logic   valid;
  logic   last;
  // row-major, oldest row first, leftmost column first
  pixel_t pix [NTAP];

  modport src (
    output valid, last, pix
  );

  modport dst (
    input valid, last, pix
  );

endinterface

/* conv_stream.f */
common/conv_pkg.sv
common/ctrl_if.sv
common/window_if.sv
linebuf/mem_sp.sv
linebuf/linebuf.sv
source/conv_ctrl.sv
source/conv_mac.sv
source/conv_result.sv
source/conv_top.sv
tb/conv_check.sv
tb/conv_tb.sv

/* linebuf/linebuf.sv */
module linebuf
  import conv_pkg::*;
  ( input  logic   clk
  , input  logic   xrst
  , ctrl_if.buf_side bs
  , input  pixel_t pix_q
  , window_if.src  win
  );

  typedef logic [$clog2(KSIZE)-1:0] sel_t;

  pixel_t             rdata [KSIZE];
  pixel_t             new_col [KSIZE];
  pixel_t             col0 [KSIZE];
  pixel_t             col1 [KSIZE];
  pixel_t             pix_d;
  sel_t               sel_q;
  logic               wr_q;
  logic               valid_q;
  logic               last_q;

  // one memory per row, rotated by line_sel; only the current row is written
  for (genvar i = 0; i < KSIZE; i++) begin : g_line
    mem_sp u_mem (
      .clk   (clk),
      .we    (bs.wr && bs.line_sel == sel_t'(i)),
      .addr  (bs.col),
      .wdata (pix_q),
      .rdata (rdata[i])
    );
  end

  // second stage follows the memory read
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_q    <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      sel_q   <= '0;
    end else begin
      wr_q    <= bs.wr;
      valid_q <= bs.wr && bs.win_ok;
      last_q  <= bs.wr && bs.last;
      if (bs.wr) begin
        sel_q <= bs.line_sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bs.wr) begin
      pix_d <= pix_q;
    end
  end

  // the two stored rows come from the memories not being written
  always_comb begin
    case (sel_q)
      sel_t'(0): begin
        new_col[0] = rdata[1];
        new_col[1] = rdata[2];
      end
      sel_t'(1): begin
        new_col[0] = rdata[2];
        new_col[1] = rdata[0];
      end
      default: begin
        new_col[0] = rdata[0];
        new_col[1] = rdata[1];
      end
    endcase
    new_col[2] = pix_d;
  end

  // older columns shift only when a pixel arrives, so gaps hold the window
  always_ff @(posedge clk) begin
    if (wr_q) begin
      for (int r = 0; r < KSIZE; r++) begin
        col0[r] <= col1[r];
        col1[r] <= new_col[r];
      end
    end
  end

  for (genvar r = 0; r < KSIZE; r++) begin : g_win
    assign win.pix[r*KSIZE]     = col0[r];
    assign win.pix[r*KSIZE + 1] = col1[r];
    assign win.pix[r*KSIZE + 2] = new_col[r];
  end

  assign win.valid = valid_q;
  assign win.last  = last_q;

  a_line_sel: assert property (
    @(posedge clk) disable iff (!xrst)
    bs.wr |-> bs.line_sel < KSIZE
  );

endmodule

/* linebuf/mem_sp.sv */
module mem_sp
  import conv_pkg::*;
  ( input  logic              clk
  , input  logic              we
  , input  logic [ADDR_W-1:0] addr
  , input  pixel_t            wdata
  , output pixel_t            rdata
  );

  pixel_t mem [IMG_MAX];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // read-first, one cycle latency
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

/* source/conv_ctrl.sv */
module conv_ctrl
  import conv_pkg::*;
  ( input  logic              clk
  , input  logic              xrst
  , input  logic              start
  , input  logic [SIZE_W-1:0] img_size
  , input  bias_t             bias
  , input  logic              wt_we
  , input  logic [ADDR_W-1:0] wt_addr
  , input  weight_t           wt_data
  , input  logic              pix_valid
  , input  pixel_t            pix_data
  , output logic              busy
  , output weight_t           weights [NTAP]
  , output bias_t             bias_q
  , output pixel_t            pix_q
  , ctrl_if.ctrl              cb
  );

  logic [SIZE_W-1:0]         size_q;
  logic [SIZE_W-1:0]         size_m1;
  logic [ADDR_W-1:0]         col_cnt;
  logic [ADDR_W-1:0]         row_cnt;
  logic [$clog2(KSIZE)-1:0]  line_cnt;
  logic                      accept;
  logic                      col_end;
  logic                      row_end;

  assign size_m1 = size_q - 1'b1;
  assign accept  = busy && pix_valid;
  assign col_end = {1'b0, col_cnt} == size_m1;
  assign row_end = {1'b0, row_cnt} == size_m1;

  // frame configuration and weights, frozen during a frame
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      size_q <= img_size;
      bias_q <= bias;
    end
    if (wt_we && !busy && wt_addr < NTAP) begin
      weights[wt_addr] <= wt_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy     <= 1'b0;
      col_cnt  <= '0;
      row_cnt  <= '0;
      line_cnt <= '0;
    end else if (!busy) begin
      busy     <= start;
      col_cnt  <= '0;
      row_cnt  <= '0;
      line_cnt <= '0;
    end else if (pix_valid) begin
      if (col_end) begin
        col_cnt  <= '0;
        line_cnt <= (line_cnt == KSIZE - 1) ? '0 : line_cnt + 1'b1;
        if (row_end) begin
          row_cnt <= '0;
          busy    <= 1'b0;
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // decoded per-pixel control, one cycle behind pix_valid
  always_ff @(posedge clk) begin
    if (!xrst) begin
      cb.wr       <= 1'b0;
      cb.win_ok   <= 1'b0;
      cb.last     <= 1'b0;
      cb.col      <= '0;
      cb.line_sel <= '0;
    end else begin
      cb.wr     <= accept;
      cb.win_ok <= accept && col_cnt >= KSIZE - 1 && row_cnt >= KSIZE - 1;
      cb.last   <= accept && col_end && row_end;
      if (accept) begin
        cb.col      <= col_cnt;
        cb.line_sel <= line_cnt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pix_q <= pix_data;
    end
  end

  a_col_range: assert property (
    @(posedge clk) disable iff (!xrst)
    busy |-> {1'b0, col_cnt} < size_q
  );

  a_no_wt_busy: assert property (
    @(posedge clk) disable iff (!xrst)
    !(wt_we && busy)
  );

endmodule

/* source/conv_mac.sv */
module conv_mac
  import conv_pkg::*;
  ( input  logic    clk
  , input  logic    xrst
  , window_if.dst   win
  , input  weight_t weights [NTAP]
  , output logic    valid
  , output logic    last
  , output acc_t    sum
  );

  acc_t prod [NTAP];
  acc_t tree;
  logic prod_valid;
  logic prod_last;

  // signed operands widen to the accumulator before the multiply
  always_ff @(posedge clk) begin
    for (int i = 0; i < NTAP; i++) begin
      prod[i] <= win.pix[i] * weights[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      prod_valid <= 1'b0;
      prod_last  <= 1'b0;
    end else begin
      prod_valid <= win.valid;
      prod_last  <= win.valid && win.last;
    end
  end

  // adder tree over the nine products
  always_comb begin
    tree = '0;
    for (int i = 0; i < NTAP; i++) begin
      tree = tree + prod[i];
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      sum <= tree;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      valid <= 1'b0;
      last  <= 1'b0;
    end else begin
      valid <= prod_valid;
      last  <= prod_last;
    end
  end

endmodule

/* source/conv_result.sv */
module conv_result
  import conv_pkg::*;
  ( input  logic              clk
  , input  logic              xrst
  , input  logic              valid
  , input  logic              last
  , input  acc_t              sum
  , input  bias_t             bias_q
  , output logic              out_valid
  , output logic              out_last
  , output logic [DATA_W-1:0] out_data
  );

  acc_t              biased;
  acc_t              shifted;
  logic [DATA_W-1:0] sat;

  assign biased  = sum + acc_t'(bias_q);
  assign shifted = biased >>> OUT_SHIFT;

  // relu, then clamp to the positive range of a signed byte
  always_comb begin
    if (shifted < 0) begin
      sat = '0;
    end else if (shifted > acc_t'(2**(DATA_W-1) - 1)) begin
      sat = DATA_W'(2**(DATA_W-1) - 1);
    end else begin
      sat = shifted[DATA_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= valid;
      out_last  <= last;
      if (valid) begin
        out_data <= sat;
      end
    end
  end

  a_last_valid: assert property (
    @(posedge clk) disable iff (!xrst)
    out_last |-> out_valid
  );

endmodule

/* source/conv_top.sv */
module conv_top
  import conv_pkg::*;
  ( input  logic              clk
  , input  logic              xrst
  , input  logic              wt_we
  , input  logic [ADDR_W-1:0] wt_addr
  , input  weight_t           wt_data
  , input  logic              start
  , input  logic [SIZE_W-1:0] img_size
  , input  bias_t             bias
  , output logic              busy
  , input  logic              pix_valid
  , input  pixel_t            pix_data
  , output logic              out_valid
  , output logic              out_last
  , output logic [DATA_W-1:0] out_data
  );

  weight_t weights [NTAP];
  bias_t   bias_q;
  pixel_t  pix_q;
  logic    mac_valid;
  logic    mac_last;
  acc_t    mac_sum;

  ctrl_if   cif ();
  window_if wif ();

  conv_ctrl u_ctrl (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .img_size  (img_size),
    .bias      (bias),
    .wt_we     (wt_we),
    .wt_addr   (wt_addr),
    .wt_data   (wt_data),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .busy      (busy),
    .weights   (weights),
    .bias_q    (bias_q),
    .pix_q     (pix_q),
    .cb        (cif.ctrl)
  );

  linebuf u_linebuf (
    .clk   (clk),
    .xrst  (xrst),
    .bs    (cif.buf_side),
    .pix_q (pix_q),
    .win   (wif.src)
  );

  conv_mac u_mac (
    .clk     (clk),
    .xrst    (xrst),
    .win     (wif.dst),
    .weights (weights),
    .valid   (mac_valid),
    .last    (mac_last),
    .sum     (mac_sum)
  );

  conv_result u_result (
    .clk       (clk),
    .xrst      (xrst),
    .valid     (mac_valid),
    .last      (mac_last),
    .sum       (mac_sum),
    .bias_q    (bias_q),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_data  (out_data)
  );

endmodule

/* tb/conv_check.sv */
module conv_check
  import conv_pkg::*;
  ( input  logic              clk
  , input  logic              xrst
  , input  logic              wt_we
  , input  logic [ADDR_W-1:0] wt_addr
  , input  weight_t           wt_data
  , input  logic              start
  , input  logic [SIZE_W-1:0] img_size
  , input  bias_t             bias
  , input  logic              busy
  , input  logic              pix_valid
  , input  pixel_t            pix_data
  , input  logic              out_valid
  , input  logic              out_last
  , input  logic [DATA_W-1:0] out_data
  , output int                errors
  , output int                tests
  , output int                frame_outs
  );

  int   wt [NTAP];
  int   img [IMG_MAX][IMG_MAX];
  int   fsize;
  int   bias_v;
  int   row;
  int   col;
  int   cycle;
  int   frame_errs;
  logic drop_due;
  logic rise_due;
  int   exp_data [$];
  bit   exp_last [$];
  int   exp_due [$];

  // window sum plus bias, arithmetic shift, relu, clamp to 127
  function automatic int expected_out(input int r, input int c);
    int acc;
    acc = bias_v;
    for (int dr = 0; dr < 3; dr++) begin
      for (int dc = 0; dc < 3; dc++) begin
        acc += img[r - 2 + dr][c - 2 + dc] * wt[dr * 3 + dc];
      end
    end
    acc = acc >>> 4;
    if (acc < 0) return 0;
    if (acc > 127) return 127;
    return acc;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    errors++;
    frame_errs++;
  endtask

  task automatic close_frame();
    tests++;
    $display("test %0d: img_size %0d, %0d outputs, %0d errors",
             tests, fsize, frame_outs, frame_errs);
  endtask

  task automatic check_output();
    int d;
    bit l;
    int t;
    if (exp_due.size() == 0) begin
      note_error($sformatf("output at cycle %0d with no window pending", cycle));
    end else begin
      d = exp_data.pop_front();
      l = exp_last.pop_front();
      t = exp_due.pop_front();
      frame_outs++;
      if (t != cycle) begin
        note_error($sformatf("output came at cycle %0d but was due at cycle %0d", cycle, t));
      end
      if (out_data !== 8'(d)) begin
        note_error($sformatf("Error out_data: expected %h, got %h", 8'(d), out_data));
      end
      if (out_last !== l) begin
        note_error($sformatf("Error out_last: expected %h, got %h", l, out_last));
      end
      if (l) begin
        close_frame();
      end
    end
  endtask

  always @(posedge clk) begin
    if (!xrst) begin
      cycle    = 0;
      errors   = 0;
      tests    = 0;
      drop_due = 1'b0;
      rise_due = 1'b0;
    end else begin
      cycle++;
      if (drop_due && busy) note_error("busy still high after the frame's last pixel");
      if (rise_due && !busy) note_error("busy did not rise after start");
      drop_due = 1'b0;
      rise_due = 1'b0;
      if (wt_we && !busy && wt_addr < NTAP) begin
        wt[wt_addr] = wt_data;
      end
      if (start && !busy) begin
        fsize      = img_size;
        bias_v     = bias;
        row        = 0;
        col        = 0;
        frame_outs = 0;
        frame_errs = 0;
        rise_due   = 1'b1;
      end
      if (busy && pix_valid) begin
        img[row][col] = pix_data;
        if (row >= 2 && col >= 2) begin
          exp_data.push_back(expected_out(row, col));
          exp_last.push_back(row == fsize - 1 && col == fsize - 1);
          exp_due.push_back(cycle + 5);
        end
        if (col == fsize - 1) begin
          col = 0;
          if (row == fsize - 1) begin
            row      = 0;
            drop_due = 1'b1;
          end else begin
            row++;
          end
        end else begin
          col++;
        end
      end
      if (out_valid) check_output();
      while (exp_due.size() > 0 && exp_due[0] < cycle) begin
        note_error($sformatf("no output for the window due at cycle %0d", exp_due[0]));
        void'(exp_data.pop_front());
        void'(exp_due.pop_front());
        if (exp_last.pop_front()) close_frame();
      end
    end
  end

endmodule

/* tb/conv_tb.sv */
module conv_tb
  import conv_pkg::*;
  ();

  // one row per frame; wset 0 random, 1 all +127 with non-negative pixels, 2 small random
  localparam int NROW = 6;
  localparam int T_SIZE [NROW] = '{3, 5, 16, 6, 7, 4};
  localparam int T_BIAS [NROW] = '{0, 100, -50, -30000, 4000, 20};
  localparam int T_WSET [NROW] = '{0, 0, 0, 2, 1, 0};
  // bit i%8 set means an idle cycle before pixel i
  localparam logic [7:0] T_GAP [NROW] = '{8'h00, 8'h00, 8'h24, 8'h00, 8'h00, 8'hb5};
  localparam int T_NOUT [NROW] = '{1, 9, 196, 16, 25, 4};

  logic              clk;
  logic              xrst;
  logic              wt_we;
  logic [ADDR_W-1:0] wt_addr;
  weight_t           wt_data;
  logic              start;
  logic [SIZE_W-1:0] img_size;
  bias_t             bias;
  logic              busy;
  logic              pix_valid;
  pixel_t            pix_data;
  logic              out_valid;
  logic              out_last;
  logic [DATA_W-1:0] out_data;
  int                errors;
  int                tests;
  int                frame_outs;
  int                count_errs;
  logic [15:0]       lfsr;

  conv_top uut (
    .clk (clk), .xrst (xrst), .wt_we (wt_we), .wt_addr (wt_addr), .wt_data (wt_data),
    .start (start), .img_size (img_size), .bias (bias), .busy (busy),
    .pix_valid (pix_valid), .pix_data (pix_data),
    .out_valid (out_valid), .out_last (out_last), .out_data (out_data)
  );

  conv_check u_check (
    .clk (clk), .xrst (xrst), .wt_we (wt_we), .wt_addr (wt_addr), .wt_data (wt_data),
    .start (start), .img_size (img_size), .bias (bias), .busy (busy),
    .pix_valid (pix_valid), .pix_data (pix_data),
    .out_valid (out_valid), .out_last (out_last), .out_data (out_data),
    .errors (errors), .tests (tests), .frame_outs (frame_outs)
  );

  // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[6:0], fb};
    end
    return v;
  endfunction

  function automatic weight_t weight_value(input int wset);
    logic [7:0] b;
    case (wset)
      1: return weight_t'(127);
      2: begin
        b = rand_bits(4);
        return weight_t'({{4{b[3]}}, b[3:0]});
      end
      default: return weight_t'(rand_bits(8));
    endcase
  endfunction

  function automatic int watchdog_cycles();
    int n;
    n = 200;
    for (int r = 0; r < NROW; r++) begin
      n += 3 * T_SIZE[r] * T_SIZE[r];
    end
    return n;
  endfunction

  task automatic load_weights(input int wset);
    for (int a = 0; a < NTAP; a++) begin
      @(posedge clk);
      wt_we   <= 1'b1;
      wt_addr <= ADDR_W'(a);
      wt_data <= weight_value(wset);
    end
    @(posedge clk);
    wt_we <= 1'b0;
  endtask

  task automatic start_frame(input int r);
    @(posedge clk);
    start    <= 1'b1;
    img_size <= SIZE_W'(T_SIZE[r]);
    bias     <= bias_t'(T_BIAS[r]);
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic send_pixels(input int r);
    logic [7:0] v;
    for (int i = 0; i < T_SIZE[r] * T_SIZE[r]; i++) begin
      if (T_GAP[r][i % 8]) begin
        @(posedge clk);
        pix_valid <= 1'b0;
      end
      v = (T_WSET[r] == 1) ? rand_bits(7) : rand_bits(8);
      @(posedge clk);
      pix_valid <= 1'b1;
      pix_data  <= pixel_t'(v);
    end
    @(posedge clk);
    pix_valid <= 1'b0;
  endtask

  // the next frame may change weights and bias only once this one has drained
  task automatic wait_frame_end(input int r);
    do begin
      @(posedge clk);
    end while (!out_last);
    @(posedge clk);
    if (frame_outs != T_NOUT[r]) begin
      count_errs++;
      $display("frame %0d gave %0d outputs where %0d were expected", r, frame_outs, T_NOUT[r]);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles()) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles());
    $display("tests failed");
    $finish;
  end

  initial begin
    xrst       = 1'b0;
    wt_we      = 1'b0;
    wt_addr    = '0;
    wt_data    = '0;
    start      = 1'b0;
    img_size   = '0;
    bias       = '0;
    pix_valid  = 1'b0;
    pix_data   = '0;
    count_errs = 0;
    lfsr       = 16'd37;
    repeat (5) @(posedge clk);
    xrst <= 1'b1;
    @(posedge clk);
    for (int r = 0; r < NROW; r++) begin
      load_weights(T_WSET[r]);
      start_frame(r);
      send_pixels(r);
      wait_frame_end(r);
    end
    repeat (10) @(posedge clk);
    $display("%0d of %0d tests done, %0d errors", tests, NROW, errors + count_errs);
    if (errors == 0 && count_errs == 0 && tests == NROW) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
